// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_uart_axil
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: axil_pkg.sv
/* AXI4-Lite register map: addresses, status and control bit positions,
   response codes */
`default_nettype none

package axil_pkg;

    localparam logic [3:0] ADDR_DATA   = 4'h0;  // TX push on write, RX pop on read
    localparam logic [3:0] ADDR_STATUS = 4'h4;  // Read only
    localparam logic [3:0] ADDR_CTRL   = 4'h8;
    localparam logic [3:0] ADDR_CLEAR  = 4'hC;  // Write one to clear sticky flags

    localparam int ST_RX_EMPTY   = 0;
    localparam int ST_RX_FULL    = 1;
    localparam int ST_TX_EMPTY   = 2;
    localparam int ST_TX_FULL    = 3;
    localparam int ST_PARITY_ERR = 4;           // Sticky
    localparam int ST_FRAME_ERR  = 5;           // Sticky
    localparam int ST_OVERRUN    = 6;           // Sticky

    localparam int CTRL_ODD  = 0;               // Odd parity when set
    localparam int CTRL_LOOP = 1;               // TX looped into RX

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2                      // Unmapped address or TX FIFO full
    } axi_resp_t;

endpackage

`default_nettype wire

// File: axil_regs.sv
/* AXI4-Lite slave: register decode, control register, sticky error flags,
   FIFO push and pop strobes */
`timescale 1ns/1ns
`default_nettype none

module axil_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic [3:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic                wvalid,
    output logic                wready,
    output axil_pkg::axi_resp_t bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output axil_pkg::axi_resp_t rresp,
    output logic                rvalid,
    input  logic                rready,
    output logic                rx_pop,
    input  logic [7:0]          rx_pop_data,
    input  logic                rx_empty,
    input  logic                rx_full,
    input  logic                rx_valid,
    output logic                tx_push,
    output logic [7:0]          tx_push_data,
    input  logic                tx_empty,
    input  logic                tx_full,
    input  logic                parity_err,
    input  logic                frame_err,
    output logic                parity_odd,
    output logic                loopback
);
    import axil_pkg::*;

    logic [1:0]  ctrl;
    logic        par_flag;                     // Sticky error flags
    logic        frm_flag;
    logic        ovr_flag;
    logic        aw_hs;
    logic        ar_hs;
    logic        wr_ok;
    logic        rd_ok;
    logic [31:0] rd_word;
    logic [31:0] status;
    logic        clr_wr;

    assign aw_hs        = awvalid && awready; // wready rises with awready
    assign ar_hs        = arvalid && arready;
    assign tx_push      = aw_hs && awaddr == ADDR_DATA && !tx_full;
    assign tx_push_data = wdata[7:0];
    assign rx_pop       = ar_hs && araddr == ADDR_DATA && !rx_empty;
    assign clr_wr       = aw_hs && awaddr == ADDR_CLEAR;
    assign parity_odd   = ctrl[CTRL_ODD];
    assign loopback     = ctrl[CTRL_LOOP];

    always_comb
    begin
        status                = '0;
        status[ST_RX_EMPTY]   = rx_empty;
        status[ST_RX_FULL]    = rx_full;
        status[ST_TX_EMPTY]   = tx_empty;
        status[ST_TX_FULL]    = tx_full;
        status[ST_PARITY_ERR] = par_flag;
        status[ST_FRAME_ERR]  = frm_flag;
        status[ST_OVERRUN]    = ovr_flag;
    end

    // Write decode, full TX FIFO drops the byte
    always_comb
    begin
        case (awaddr)
            ADDR_DATA:                         wr_ok = !tx_full;
            ADDR_STATUS, ADDR_CTRL, ADDR_CLEAR: wr_ok = 1'b1;
            default:                           wr_ok = 1'b0;
        endcase
    end

    // Read decode, unmapped reads return zero
    always_comb
    begin
        rd_ok   = 1'b1;
        rd_word = '0;
        case (araddr)
            ADDR_DATA:
                if (!rx_empty)
                    rd_word[7:0] = rx_pop_data; // Empty FIFO reads zero
            ADDR_STATUS: rd_word = status;
            ADDR_CTRL:
            begin
                rd_word[CTRL_ODD]  = ctrl[CTRL_ODD];
                rd_word[CTRL_LOOP] = ctrl[CTRL_LOOP];
            end
            ADDR_CLEAR: rd_word = '0;
            default:    rd_ok = 1'b0;
        endcase
    end

    // Channel handshakes
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            awready <= awvalid && wvalid && !awready && !bvalid; // One-cycle pulse
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (aw_hs)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            arready <= arvalid && !arready && !rvalid;
            if (ar_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Control register and sticky flags, a new event wins over a clear
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ctrl     <= '0;
            par_flag <= 1'b0;
            frm_flag <= 1'b0;
            ovr_flag <= 1'b0;
        end
        else
        begin
            if (aw_hs && awaddr == ADDR_CTRL)
            begin
                ctrl[CTRL_ODD]  <= wdata[CTRL_ODD];
                ctrl[CTRL_LOOP] <= wdata[CTRL_LOOP];
            end
            par_flag <= parity_err || (par_flag && !(clr_wr && wdata[ST_PARITY_ERR]));
            frm_flag <= frame_err || (frm_flag && !(clr_wr && wdata[ST_FRAME_ERR]));
            ovr_flag <= (rx_valid && rx_full)  // Byte dropped by a full RX FIFO
                     || (ovr_flag && !(clr_wr && wdata[ST_OVERRUN]));
        end
    end

    always_ff @(posedge clk)
    begin
        if (aw_hs)
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        if (ar_hs)
        begin
            rdata <= rd_word;
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: byte_fifo.sv
/* 16-deep byte FIFO, circular buffer with registered full and empty flags */
`timescale 1ns/1ns
`default_nettype none

module byte_fifo (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       empty,
    output logic       full
);
    import uart_pkg::*;

    logic [7:0]       mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;                  // Extra MSB tells full from empty
    logic [FIFO_AW:0] rd_ptr;
    logic [FIFO_AW:0] wr_next;
    logic [FIFO_AW:0] rd_next;
    logic             do_push;
    logic             do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign wr_next  = do_push ? wr_ptr + 1'b1 : wr_ptr;
    assign rd_next  = do_pop ? rd_ptr + 1'b1 : rd_ptr;
    assign pop_data = mem[rd_ptr[FIFO_AW-1:0]]; // Head is visible without a pop

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end
        else
        begin
            wr_ptr <= wr_next;
            rd_ptr <= rd_next;
            empty  <= (wr_next == rd_next);
            full   <= (wr_next[FIFO_AW] != rd_next[FIFO_AW])
                   && (wr_next[FIFO_AW-1:0] == rd_next[FIFO_AW-1:0]);
        end
    end

    // Callers gate their strobes with the flags
    assert property (@(posedge clk) disable iff (reset) push |-> !full);
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

// File: sources.f
uart_pkg.sv
axil_pkg.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
axil_regs.sv
uart_axil_top.sv
tb_uart_axil.sv

// File: tb_uart_axil.sv
/* UART AXI4-Lite testbench: AXI and serial drivers, tx monitor, queue model,
   compare tasks and watchdog */
`timescale 1ns/1ns
`default_nettype none

module tb_uart_axil;
    import uart_pkg::*;
    import axil_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int FRAME_CLKS   = 12 * CLKS_PER_BIT;       // Frame plus one idle bit
    localparam int N_TX         = 5;                       // Bytes per parity mode
    localparam int N_RX         = 8;
    localparam int N_LOOP       = 4;
    localparam int TOTAL_FRAMES = 2 * N_TX + N_RX + 2 + (FIFO_DEPTH + 1) + N_LOOP
                                + (FIFO_DEPTH + 1) + 2;    // Last 2 cover the stray-frame wait
    localparam int WATCHDOG_NS  = TOTAL_FRAMES * FRAME_CLKS * CLK_PERIOD * 12 / 10;

    logic        clk = 1'b0;
    logic        reset;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;
    logic        rx;
    logic        tx;

    logic [31:0] rng_state;
    int          ready_max;                                // Upper bound of bready/rready delay
    int          byte_errs;
    int          resp_errs;
    int          status_errs;
    int          other_errs;
    string       test_name;
    logic [8:0]  exp_tx[$];                                // {parity mode, byte}
    logic [7:0]  exp_rx[$];                                // Model of the receive FIFO
    logic        odd_mode;
    logic        loop_mode;
    logic        par_f;                                    // Expected sticky flags
    logic        frm_f;
    logic        ovr_f;
    int          tx_level;                                 // Known transmit FIFO fill

    always #(CLK_PERIOD / 2) clk = ~clk;

    uart_axil_top i_uart_axil_top (
        .clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp,
        .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .rx, .tx
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Status word predicted from the model queues and flags
    function automatic logic [31:0] model_status();
        logic [31:0] s;
        s                = '0;
        s[ST_RX_EMPTY]   = (exp_rx.size() == 0);
        s[ST_RX_FULL]    = (exp_rx.size() == FIFO_DEPTH);
        s[ST_TX_EMPTY]   = (tx_level == 0);
        s[ST_TX_FULL]    = (tx_level == FIFO_DEPTH);
        s[ST_PARITY_ERR] = par_f;
        s[ST_FRAME_ERR]  = frm_f;
        s[ST_OVERRUN]    = ovr_f;
        return s;
    endfunction

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
        begin
            byte_errs++;
            $display("** Error %s %s: expected %02h, actual %02h", test_name, what, exp, act);
        end
    endtask

    task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp)
        begin
            resp_errs++;
            $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_status(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp)
        begin
            status_errs++;
            $display("** Error %s %s: expected %08h, actual %08h", test_name, what, exp, act);
        end
    endtask

    task automatic ready_wait();
        int n;
        n = int'(rand32() % (ready_max + 1));
        repeat (n) @(posedge clk);
    endtask

    // All bus tasks start and end just after a rising edge
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do
            @(posedge clk);
        while (!awready);                                  // Pre-edge value, handshake here
        if (wready !== 1'b1)
        begin
            other_errs++;
            $display("%s: wready did not rise together with awready", test_name);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        ready_wait();
        bready <= 1'b1;
        do
            @(posedge clk);
        while (!(bvalid && bready));
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output axi_resp_t resp);
        araddr  <= addr;
        arvalid <= 1'b1;
        do
            @(posedge clk);
        while (!arready);
        arvalid <= 1'b0;
        ready_wait();
        rready <= 1'b1;
        do
            @(posedge clk);
        while (!(rvalid && rready));
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                                input axi_resp_t exp);
        axi_resp_t r;
        axi_write(addr, data, r);
        check_resp("write response", exp, r);
    endtask

    task automatic read_data_reg();
        logic [31:0] d;
        axi_resp_t   r;
        logic [7:0]  exp;
        exp = 8'h00;                                       // Empty FIFO reads zero
        if (exp_rx.size() != 0)
            exp = exp_rx.pop_front();
        axi_read(ADDR_DATA, d, r);
        check_resp("DATA read response", RESP_OKAY, r);
        check_byte("DATA read", exp, d[7:0]);
    endtask

    task automatic read_status();
        logic [31:0] d;
        axi_resp_t   r;
        axi_read(ADDR_STATUS, d, r);
        check_resp("STATUS read response", RESP_OKAY, r);
        check_status("STATUS", model_status(), d);
    endtask

    task automatic set_ctrl(input logic odd, input logic loop);
        logic [31:0] w;
        w            = '0;
        w[CTRL_ODD]  = odd;
        w[CTRL_LOOP] = loop;
        write_expect(ADDR_CTRL, w, RESP_OKAY);
        odd_mode  = odd;
        loop_mode = loop;
    endtask

    // Receive FIFO model, a byte beyond 16 is an overrun
    task automatic rx_accept(input logic [7:0] b);
        if (exp_rx.size() < FIFO_DEPTH)
            exp_rx.push_back(b);
        else
            ovr_f = 1'b1;
    endtask

    task automatic send_tx_byte(input logic [7:0] b);
        write_expect(ADDR_DATA, {24'd0, b}, RESP_OKAY);
        exp_tx.push_back({odd_mode, b});
        if (loop_mode)
            rx_accept(b);                                  // Comes back through the receiver
    endtask

    task automatic serial_frame(input logic [7:0] b, input logic flip_par, input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, ((^b) ^ odd_mode) ^ flip_par, b, 1'b0}; // Stop, parity, data, start
        for (int i = 0; i < 11; i++)
        begin
            rx <= bits[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        rx <= 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk);              // Idle bit, result already pushed
    endtask

    task automatic wait_tx_drain();
        int limit;
        limit = (exp_tx.size() + 1) * FRAME_CLKS;
        while (exp_tx.size() != 0 && limit > 0)
        begin
            @(posedge clk);
            limit--;
        end
        if (exp_tx.size() != 0)
        begin
            other_errs++;
            $display("%s: %0d queued bytes never appeared on tx", test_name, exp_tx.size());
            exp_tx.delete();
        end
    endtask

    // Decodes tx frames at bit centres, start seen one edge after it falls
    always
    begin : tx_monitor
        logic [7:0] got;
        logic       par;
        logic [8:0] exp;
        @(posedge clk);
        if (!reset && tx === 1'b0)
        begin
            repeat (HALF_BIT - 1) @(posedge clk);
            for (int i = 0; i < DATA_BITS; i++)
            begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                got[i] = tx;                               // LSB first
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            par = tx;
            repeat (CLKS_PER_BIT) @(posedge clk);
            if (tx !== 1'b1)
            begin
                other_errs++;
                $display("%s: tx stop bit was not high", test_name);
            end
            if (exp_tx.size() == 0)
            begin
                other_errs++;
                $display("%s: frame %02h on tx with no byte written", test_name, got);
            end
            else
            begin
                exp = exp_tx.pop_front();
                check_byte("tx data", exp[7:0], got);
                check_byte("tx parity", {7'd0, (^exp[7:0]) ^ exp[8]}, {7'd0, par});
            end
        end
    end

    initial
    begin
        logic [31:0] d;
        axi_resp_t   r;
        rng_state   = 32'h55b356df;
        ready_max   = 3;
        byte_errs   = 0;
        resp_errs   = 0;
        status_errs = 0;
        other_errs  = 0;
        odd_mode    = 1'b0;
        loop_mode   = 1'b0;
        par_f       = 1'b0;
        frm_f       = 1'b0;
        ovr_f       = 1'b0;
        tx_level    = 0;
        reset       = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        rx          = 1'b1;                                // Idle line
        test_name   = "reset";
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        read_status();

        test_name = "tx parity";
        for (int m = 0; m < 2; m++)
        begin
            set_ctrl(m[0], 1'b0);                          // Even first, then odd
            for (int i = 0; i < N_TX; i++)
            begin
                d = rand32();
                send_tx_byte(d[7:0]);
            end
            wait_tx_drain();
        end

        test_name = "rx data";
        d = rand32();
        set_ctrl(d[0], 1'b0);
        for (int i = 0; i < N_RX; i++)
        begin
            d = rand32();
            serial_frame(d[7:0], 1'b0, 1'b0);
            rx_accept(d[7:0]);
        end
        read_status();
        repeat (N_RX + 1) read_data_reg();                 // Last read finds it empty
        read_status();

        test_name = "rx errors";
        d = rand32();
        serial_frame(d[7:0], 1'b1, 1'b0);                  // Flipped parity bit
        par_f = 1'b1;
        read_status();
        write_expect(ADDR_CLEAR, 32'd1 << ST_PARITY_ERR, RESP_OKAY);
        par_f = 1'b0;
        read_status();
        d = rand32();
        serial_frame(d[7:0], 1'b0, 1'b1);                  // Low stop bit
        frm_f = 1'b1;
        read_status();
        write_expect(ADDR_CLEAR, 32'd1 << ST_FRAME_ERR, RESP_OKAY);
        frm_f = 1'b0;
        read_status();

        test_name = "rx overrun";
        repeat (FIFO_DEPTH + 1)
        begin
            d = rand32();
            serial_frame(d[7:0], 1'b0, 1'b0);
            rx_accept(d[7:0]);
        end
        read_status();
        repeat (FIFO_DEPTH + 1) read_data_reg();
        write_expect(ADDR_CLEAR, 32'd1 << ST_OVERRUN, RESP_OKAY);
        ovr_f = 1'b0;
        read_status();

        test_name = "loopback";
        d = rand32();
        set_ctrl(d[0], 1'b1);
        for (int i = 0; i < N_LOOP; i++)
        begin
            d = rand32();
            send_tx_byte(d[7:0]);
        end
        wait_tx_drain();
        repeat (2 * CLKS_PER_BIT) @(posedge clk);          // Receiver result trails tx stop bit
        repeat (N_LOOP) read_data_reg();
        set_ctrl(odd_mode, 1'b0);
        read_status();

        test_name = "slave errors";
        d = rand32();
        axi_write({d[3:2], 2'b10}, d, r);                  // Never a register address
        check_resp("unmapped write", RESP_SLVERR, r);
        axi_read({d[5:4], 2'b01}, d, r);
        check_resp("unmapped read", RESP_SLVERR, r);
        check_status("unmapped read data", 32'h0, d);
        ready_max = 0;                                     // Writes outrun the transmitter
        repeat (FIFO_DEPTH + 1)
        begin
            d = rand32();
            send_tx_byte(d[7:0]);                          // One leaves at once, 16 stay
        end
        d = rand32();
        write_expect(ADDR_DATA, {24'd0, d[7:0]}, RESP_SLVERR);
        tx_level = FIFO_DEPTH;
        read_status();
        ready_max = 3;
        tx_level  = 0;
        wait_tx_drain();
        repeat (2 * FRAME_CLKS) @(posedge clk);            // Dropped byte would show up here
        read_status();

        $display("Errors: byte %0d, response %0d, status %0d, other %0d",
                 byte_errs, resp_errs, status_errs, other_errs);
        if (byte_errs + resp_errs + status_errs + other_errs == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_axil_top.sv
/* UART peripheral top: receiver, RX and TX FIFOs, AXI4-Lite registers,
   transmitter and loopback multiplexer */
`timescale 1ns/1ns
`default_nettype none

module uart_axil_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [3:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic                wvalid,
    output logic                wready,
    output axil_pkg::axi_resp_t bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output axil_pkg::axi_resp_t rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic                rx,
    output logic                tx
);
    logic       rx_line;                       // Receiver input after loopback mux
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       parity_err;
    logic       frame_err;
    logic       rx_pop;
    logic [7:0] rx_pop_data;
    logic       rx_empty;
    logic       rx_full;
    logic       tx_push;
    logic [7:0] tx_push_data;
    logic [7:0] tx_pop_data;
    logic       tx_empty;
    logic       tx_full;
    logic       tx_ready;
    logic       parity_odd;
    logic       loopback;

    assign rx_line = loopback ? tx : rx;       // tx pin keeps driving either way

    uart_rx i_uart_rx (
        .clk, .reset, .rx(rx_line), .parity_odd, .rx_data, .rx_valid, .parity_err, .frame_err
    );

    // Bytes arriving on a full FIFO are dropped and counted as overrun
    byte_fifo i_rx_fifo (
        .clk, .reset, .push(rx_valid && !rx_full), .push_data(rx_data),
        .pop(rx_pop), .pop_data(rx_pop_data), .empty(rx_empty), .full(rx_full)
    );

    axil_regs i_axil_regs (
        .clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp,
        .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .rx_pop, .rx_pop_data, .rx_empty, .rx_full, .rx_valid, .tx_push, .tx_push_data,
        .tx_empty, .tx_full, .parity_err, .frame_err, .parity_odd, .loopback
    );

    byte_fifo i_tx_fifo (
        .clk, .reset, .push(tx_push), .push_data(tx_push_data),
        .pop(tx_ready && !tx_empty), .pop_data(tx_pop_data), .empty(tx_empty), .full(tx_full)
    );

    uart_tx i_uart_tx (
        .clk, .reset, .tx_data(tx_pop_data), .tx_valid(!tx_empty), .parity_odd,
        .tx_ready, .tx
    );

endmodule

`default_nettype wire

// File: uart_pkg.sv
/* Serial frame timing constants, FIFO sizing and the receiver and
   transmitter FSM state encodings */
`default_nettype none

package uart_pkg;

    localparam int CLKS_PER_BIT = 8;           // Fixed bit time, no baud divider
    localparam int HALF_BIT     = 4;           // Falling edge to start-bit centre
    localparam int DATA_BITS    = 8;           // Payload bits per frame
    localparam int FIFO_DEPTH   = 16;          // Entries per byte FIFO
    localparam int FIFO_AW      = 4;           // log2 of FIFO_DEPTH

    // Receiver FSM, one state per frame field
    typedef enum logic [2:0] {
        RX_IDLE,                               // Waiting for a low line
        RX_START,                              // Half-bit start validation
        RX_DATA,                               // LSB first payload
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // Transmitter FSM mirrors the receiver fields
    typedef enum logic [2:0] {
        TX_IDLE,                               // Line high, ready for a byte
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

// File: uart_rx.sv
/* Serial receiver with input synchronizer, start-bit validation,
   parity and stop-bit checks */
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    input  logic       parity_odd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       parity_err,
    output logic       frame_err
);
    import uart_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam int BW = $clog2(DATA_BITS);

    rx_state_t     state;
    logic [CW-1:0] cnt;                        // Clocks within current bit
    logic [BW-1:0] bit_idx;
    logic          rx_meta;                    // First synchronizer stage
    logic          rx_sync;
    logic [7:0]    shift;                      // LSB arrives first
    logic          par_bit;
    logic          bit_end;
    logic          par_bad;

    assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));
    assign par_bad = ((^shift) ^ par_bit) != parity_odd;
    assign rx_data = shift;

    // Payload capture at bit centres
    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && bit_end)
            shift <= {rx_sync, shift[7:1]};
        if (state == RX_PARITY && bit_end)
            par_bit <= rx_sync;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta    <= 1'b1;                // Idle line is high
            rx_sync    <= 1'b1;
            state      <= RX_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
        end
        else
        begin
            rx_meta    <= rx;
            rx_sync    <= rx_meta;
            rx_valid   <= 1'b0;                // Result outputs are single pulses
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    cnt <= '0;
                    if (!rx_sync)
                        state <= RX_START;     // Candidate start edge
                end
                RX_START:
                begin
                    if (cnt == CW'(HALF_BIT - 1))
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA; // Glitch returns quietly
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                RX_DATA:
                begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BW'(DATA_BITS - 1))
                            state <= RX_PARITY;
                    end
                end
                RX_PARITY:
                begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end)
                        state <= RX_STOP;
                end
                RX_STOP:
                begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end)
                    begin
                        state      <= RX_IDLE;
                        frame_err  <= !rx_sync; // Stop bit must be high
                        parity_err <= par_bad;
                        rx_valid   <= rx_sync && !par_bad;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // A byte is never delivered alongside an error report
    assert property (@(posedge clk) disable iff (reset)
        !(rx_valid && (parity_err || frame_err)));

endmodule

`default_nettype wire

// File: uart_tx.sv
/* Serial transmitter: start bit, LSB-first data, parity bit, one stop bit */
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    input  logic       parity_odd,
    output logic       tx_ready,
    output logic       tx
);
    import uart_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam int BW = $clog2(DATA_BITS);

    tx_state_t     state;
    logic [CW-1:0] cnt;
    logic [BW-1:0] bit_idx;
    logic [7:0]    shift;
    logic          par_bit;                    // Computed once at acceptance
    logic          bit_end;
    logic          accept;

    assign tx_ready = (state == TX_IDLE);
    assign accept   = tx_valid && tx_ready;
    assign bit_end  = (cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            shift   <= tx_data;
            par_bit <= (^tx_data) ^ parity_odd; // Parity mode latched per frame
        end
        else if (state == TX_DATA && bit_end)
            shift <= shift >> 1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;                   // Line idles high
        end
        else
        begin
            cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE:
                    if (accept)
                    begin
                        state <= TX_START;
                        tx    <= 1'b0;
                    end
                TX_START:
                    if (bit_end)
                    begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx      <= shift[0];
                    end
                TX_DATA:
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BW'(DATA_BITS - 1))
                        begin
                            state <= TX_PARITY;
                            tx    <= par_bit;
                        end
                        else
                            tx <= shift[1]; // Next bit, shift happens this edge
                    end
                TX_PARITY:
                    if (bit_end)
                    begin
                        state <= TX_STOP;
                        tx    <= 1'b1;
                    end
                TX_STOP:
                    if (bit_end)
                        state <= TX_IDLE;   // Ready again the next cycle
                default: state <= TX_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) state == TX_IDLE |-> tx);

endmodule

`default_nettype wire
